// ==== tb.f ====
+incdir+.
mips_pkg.sv
pc_reg.sv
pipe_reg.sv
id.sv
regfile.sv
ex.sv
openmips.sv
tb_openmips.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_openmips \
    -f tb.f -o sim_tb || exit 1
out=$(./obj_dir/sim_tb)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "sim passed" && exit 0 || exit 1

// ==== tb_program.svh ====
// included inside the testbench module; builders fill prog, build_expected turns prog into exp_q
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

function automatic inst_t enc_r(input logic [5:0] fn, input raddr_t rd, input raddr_t rs,
                                input raddr_t rt, input logic [4:0] sa);
    return {OP_SPECIAL, rs, rt, rd, sa, fn};
endfunction

function automatic inst_t enc_i(input logic [5:0] op, input raddr_t rt, input raddr_t rs,
                                input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

// reference model runs prog in order on 32 registers
function automatic void build_expected();
    reg_t   model [32];
    inst_t  w;
    reg_t   a;
    reg_t   b;
    reg_t   res;
    raddr_t dst;
    logic   ok;
    exp_t   e;
    exp_q.delete();
    for (int i = 0; i < 32; i++) begin
        model[i] = '0;
    end
    foreach (prog[k]) begin
        w   = prog[k];
        a   = model[w[25:21]];        // rs
        b   = model[w[20:16]];        // rt
        dst = w[20:16];
        ok  = 1'b1;
        res = '0;
        case (w[31:26])
            OP_SPECIAL: begin
                dst = w[15:11];
                case (w[5:0])
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_XOR:  res = a ^ b;
                    FN_NOR:  res = ~(a | b);
                    FN_SLL:  res = b << w[10:6];
                    FN_SRL:  res = b >> w[10:6];
                    FN_SRA:  res = (b >> w[10:6]) | (b[31] ? ~(32'hffffffff >> w[10:6]) : 32'h0);
                    default: ok = 1'b0;
                endcase
            end
            OP_ANDI: res = a & {16'h0, w[15:0]};
            OP_ORI:  res = a | {16'h0, w[15:0]};
            OP_XORI: res = a ^ {16'h0, w[15:0]};
            OP_LUI:  res = {w[15:0], 16'h0};
            default: ok = 1'b0;
        endcase
        if (ok && dst != 5'd0) begin
            model[dst]  = res;
            e.idx       = 32'(k);
            e.rec.we    = 1'b1;
            e.rec.waddr = dst;
            e.rec.wdata = res;
            exp_q.push_back(e);
        end
    end
endfunction

function automatic void load_itype_chain();
    prog.delete();
    prog.push_back(enc_i(OP_ORI,  5'd1, 5'd0, 16'h1234));
    prog.push_back(enc_i(OP_LUI,  5'd2, 5'd0, 16'habcd));
    prog.push_back(enc_i(OP_XORI, 5'd3, 5'd1, 16'hffff));
    prog.push_back(enc_i(OP_ANDI, 5'd4, 5'd3, 16'h0f0f));
    prog.push_back(enc_i(OP_ORI,  5'd5, 5'd2, 16'h5678));
endfunction

function automatic void load_forwarding();
    prog.delete();
    prog.push_back(enc_i(OP_ORI,  5'd1, 5'd0, 16'h00ff));
    prog.push_back(enc_i(OP_XORI, 5'd2, 5'd1, 16'h0ff0));    // r1 from EX
    prog.push_back(enc_r(FN_OR,   5'd3, 5'd1, 5'd2, 5'd0));   // r1 from MEM, r2 from EX
    prog.push_back(enc_r(FN_AND,  5'd4, 5'd1, 5'd3, 5'd0));   // r1 from WB
    prog.push_back(enc_i(OP_ORI,  5'd1, 5'd0, 16'h1111));
    prog.push_back(enc_i(OP_ORI,  5'd1, 5'd1, 16'h2222));
    prog.push_back(enc_r(FN_XOR,  5'd5, 5'd1, 5'd2, 5'd0));   // EX copy beats MEM copy
    prog.push_back(enc_i(OP_ORI,  5'd8, 5'd0, 16'haaaa));
    prog.push_back(enc_i(OP_ORI,  5'd8, 5'd0, 16'h5555));
    prog.push_back('0);
    prog.push_back(enc_r(FN_NOR,  5'd9, 5'd8, 5'd0, 5'd0));   // MEM copy beats WB copy
    prog.push_back(enc_r(FN_SLL,  5'd10, 5'd0, 5'd9, 5'd4));
    prog.push_back(enc_i(OP_ORI,  5'd4, 5'd0, 16'h0001));
    prog.push_back('0);
    prog.push_back('0);
    prog.push_back(enc_r(FN_OR,   5'd11, 5'd4, 5'd0, 5'd0));  // WB copy beats stored r4
endfunction

function automatic void load_rtype();
    logic [15:0] hi;
    logic [4:0]  sa;
    prog.delete();
    for (int r = 1; r <= 4; r++) begin
        hi = 16'($urandom);
        if (r % 2 == 0) begin
            hi[15] = 1'b1;             // r2 and r4 negative
        end
        prog.push_back(enc_i(OP_LUI, 5'(r), 5'd0, hi));
        prog.push_back(enc_i(OP_ORI, 5'(r), 5'(r), 16'($urandom)));
    end
    sa = 5'($urandom);
    prog.push_back(enc_r(FN_AND, 5'd5,  5'd1, 5'd2, 5'd0));
    prog.push_back(enc_r(FN_OR,  5'd6,  5'd3, 5'd4, 5'd0));
    prog.push_back(enc_r(FN_XOR, 5'd7,  5'd1, 5'd4, 5'd0));
    prog.push_back(enc_r(FN_NOR, 5'd8,  5'd2, 5'd3, 5'd0));
    prog.push_back(enc_r(FN_SLL, 5'd9,  5'd0, 5'd1, sa));
    prog.push_back(enc_r(FN_SRL, 5'd10, 5'd0, 5'd2, sa));
    prog.push_back(enc_r(FN_SRA, 5'd11, 5'd0, 5'd2, sa));
    prog.push_back(enc_r(FN_SRA, 5'd12, 5'd0, 5'd4, 5'd31));
    prog.push_back(enc_r(FN_SRA, 5'd13, 5'd0, 5'd3, sa));
    prog.push_back(enc_r(FN_SRL, 5'd14, 5'd0, 5'd4, 5'd31));
endfunction

function automatic void load_r0();
    prog.delete();
    prog.push_back(enc_i(OP_ORI,  5'd0, 5'd0, 16'hffff));
    prog.push_back(enc_i(OP_LUI,  5'd0, 5'd0, 16'h1234));
    prog.push_back(enc_r(FN_OR,   5'd1, 5'd0, 5'd0, 5'd0));   // r0 writes still in flight
    prog.push_back(enc_i(OP_ORI,  5'd2, 5'd0, 16'h00aa));
    prog.push_back(enc_r(FN_NOR,  5'd0, 5'd2, 5'd2, 5'd0));
    prog.push_back(enc_i(OP_XORI, 5'd3, 5'd0, 16'h0f0f));
    prog.push_back('0);
    prog.push_back('0);
    prog.push_back('0);
    prog.push_back(enc_r(FN_SRA,  5'd4, 5'd0, 5'd0, 5'd7));
endfunction

function automatic void load_random(input int n);
    raddr_t      rd;
    raddr_t      rs;
    raddr_t      rt;
    logic [4:0]  sa;
    logic [15:0] imm;
    inst_t       w;
    prog.delete();
    for (int i = 0; i < n; i++) begin
        rd  = 5'($urandom_range(7, 0));    // few registers, many dependencies
        rs  = 5'($urandom_range(7, 0));
        rt  = 5'($urandom_range(7, 0));
        sa  = 5'($urandom);
        imm = 16'($urandom);
        case ($urandom_range(11, 0))
            0:       w = enc_r(FN_AND, rd, rs, rt, 5'd0);
            1:       w = enc_r(FN_OR,  rd, rs, rt, 5'd0);
            2:       w = enc_r(FN_XOR, rd, rs, rt, 5'd0);
            3:       w = enc_r(FN_NOR, rd, rs, rt, 5'd0);
            4:       w = enc_r(FN_SLL, rd, 5'd0, rt, sa);
            5:       w = enc_r(FN_SRL, rd, 5'd0, rt, sa);
            6:       w = enc_r(FN_SRA, rd, 5'd0, rt, sa);
            7:       w = enc_i(OP_ANDI, rt, rs, imm);
            8:       w = enc_i(OP_ORI,  rt, rs, imm);
            9:       w = enc_i(OP_XORI, rt, rs, imm);
            10:      w = enc_i(OP_LUI,  rt, 5'd0, imm);
            default: w = '0;                 // nop
        endcase
        prog.push_back(w);
    end
endfunction

`endif

// ==== tb_openmips.sv ====
// programs start at word 0 with RESET_PC 0; 256-word ROM returns nops past the program
module tb_openmips import mips_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ROM_WORDS    = 256;
    localparam int RESET_CYCLES = 16;

    typedef struct packed {
        logic [31:0] idx;      // program index of the producing instruction
        wb_t         rec;
    } exp_t;

    logic   clk;
    logic   rst_n_i;
    inst_t  rom_data_i;
    logic   rom_ce_o;
    addr_t  rom_addr_o;
    wb_t    wb_o;

    inst_t  rom [ROM_WORDS];
    inst_t  prog [$];
    exp_t   exp_q [$];
    int     cyc;               // fetch cycle being sampled (-1 before the first fetch)
    int     test_errs;
    int     tnum;
    string  cur_name;
    int     pass_cnt;
    int     fail_cnt;
    longint budget_ns = 0;

    `include "tb_program.svh"

    openmips #(
        .RESET_PC('0)
    ) u_openmips (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rom_data_i (rom_data_i),
        .rom_ce_o   (rom_ce_o),
        .rom_addr_o (rom_addr_o),
        .wb_o       (wb_o)
    );

    // combinational instruction ROM
    assign rom_data_i = rom_ce_o ? rom[rom_addr_o[9:2]] : '0;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // samples the values that held during the cycle just ended
    always @(posedge clk) begin
        exp_t e;
        if (!rst_n_i) begin
            cyc = -1;
        end else begin
            assert ((cyc < 0) ? !rom_ce_o : (rom_ce_o && rom_addr_o == addr_t'(4 * cyc)))
            else begin
                $display("FAIL %0t: fetch in cycle %0d expected ce %0b addr %h, got %0b %h",
                         $time, cyc, cyc >= 0, addr_t'(4 * cyc), rom_ce_o, rom_addr_o);
                test_errs++;
            end
            assert (!wb_o.we || exp_q.size() != 0)
            else begin
                $display("test %0d %s: extra write-back to r%0d at %0t after the last result",
                         tnum, cur_name, wb_o.waddr, $time);
                test_errs++;
            end
            if (wb_o.we && exp_q.size() != 0) begin
                e = exp_q.pop_front();
                assert (wb_o == e.rec && cyc == int'(e.idx) + 4)
                else begin
                    $display("FAIL %0t: expected r%0d=%h in cycle %0d, got r%0d=%h in cycle %0d",
                             $time, e.rec.waddr, e.rec.wdata, int'(e.idx) + 4,
                             wb_o.waddr, wb_o.wdata, cyc);
                    test_errs++;
                end
            end
            cyc = cyc + 1;
        end
    end

    task automatic run_test(input string name);
        int len;
        len = prog.size();
        tnum++;
        cur_name = name;
        budget_ns += longint'(RESET_CYCLES + len + 10) * 20;
        @(posedge clk);
        rst_n_i <= 1'b0;
        @(posedge clk);
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = (i < len) ? prog[i] : '0;
        end
        build_expected();
        test_errs = 0;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        rst_n_i <= 1'b1;
        repeat (len + 6) @(posedge clk);   // last result shows up len + 4 edges after release
        @(negedge clk);
        assert (exp_q.size() == 0)
        else begin
            $display("test %0d %s: %0d write-back records never arrived",
                     tnum, name, exp_q.size());
            test_errs += exp_q.size();
        end
        if (test_errs == 0) begin
            pass_cnt++;
            $display("test %0d %s: ok", tnum, name);
        end else begin
            fail_cnt++;
            $display("test %0d %s: %0d errors", tnum, name, test_errs);
        end
    endtask

    initial begin
        rst_n_i  = 1'b0;
        tnum     = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        void'($urandom(32'h5fc62ab8));
        load_itype_chain();
        run_test("itype chain");
        load_forwarding();
        run_test("forwarding");
        load_rtype();
        run_test("rtype random operands");
        load_r0();
        run_test("r0 and nops");
        load_random(60);
        run_test("random program");
        $display("tests done, %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // watchdog budget grows as each test starts
    initial begin
        while ($time <= budget_ns) begin
            @(posedge clk);
        end
        $display("watchdog: run did not finish within %0d ns", budget_ns);
        $display("sim failed");
        $finish;
    end

endmodule

// ==== openmips.sv ====
// ROM must answer combinationally and return 0 when rom_ce_o is low; no data memory, MEM is a bare register
module openmips import mips_pkg::*; #(
    parameter addr_t RESET_PC = '0
) (
    input  logic  clk,
    input  logic  rst_n_i,
    input  inst_t rom_data_i,
    output logic  rom_ce_o,
    output addr_t rom_addr_o,
    output wb_t   wb_o          // write-back port, for debug
);

    if_id_t if_id_d;            // IF
    if_id_t if_id_q;

    logic   re1;                // ID to regfile
    raddr_t raddr1;
    logic   re2;
    raddr_t raddr2;
    reg_t   rdata1;
    reg_t   rdata2;

    id_ex_t id_ex_d;
    id_ex_t id_ex_q;

    wb_t    ex_wb;              // EX result, also the EX forwarding source
    wb_t    mem_wb;             // MEM forwarding source

    pc_reg #(
        .RESET_PC(RESET_PC)
    ) u_pc_reg (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .pc_o    (rom_addr_o),
        .ce_o    (rom_ce_o)
    );

    assign if_id_d = '{pc: rom_addr_o, inst: rom_data_i};

    pipe_reg #(.T(if_id_t)) u_if_id (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .d_i     (if_id_d),
        .q_o     (if_id_q)
    );

    id u_id (
        .if_id_i  (if_id_q),
        .rdata1_i (rdata1),
        .rdata2_i (rdata2),
        .re1_o    (re1),
        .raddr1_o (raddr1),
        .re2_o    (re2),
        .raddr2_o (raddr2),
        .id_ex_o  (id_ex_d)
    );

    regfile u_regfile (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .ex_fwd_i  (ex_wb),
        .mem_fwd_i (mem_wb),
        .wb_i      (wb_o),
        .re1_i     (re1),
        .raddr1_i  (raddr1),
        .re2_i     (re2),
        .raddr2_i  (raddr2),
        .rdata1_o  (rdata1),
        .rdata2_o  (rdata2)
    );

    pipe_reg #(.T(id_ex_t)) u_id_ex (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .d_i     (id_ex_d),
        .q_o     (id_ex_q)
    );

    ex u_ex (
        .id_ex_i (id_ex_q),
        .wb_o    (ex_wb)
    );

    pipe_reg #(.T(wb_t)) u_ex_mem (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .d_i     (ex_wb),
        .q_o     (mem_wb)
    );

    pipe_reg #(.T(wb_t)) u_mem_wb (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .d_i     (mem_wb),
        .q_o     (wb_o)
    );

endmodule

// ==== ex.sv ====
// purely combinational; shift amount is op2[4:0], lui takes the immediate from op2[15:0]
module ex import mips_pkg::*; (
    input  id_ex_t id_ex_i,
    output wb_t    wb_o
);

    reg_t       op1;
    reg_t       op2;
    logic [4:0] shamt;
    reg_t       logic_res;
    reg_t       shift_res;
    reg_t       result;

    assign op1   = id_ex_i.op1;
    assign op2   = id_ex_i.op2;
    assign shamt = op2[4:0];

    always_comb begin
        case (id_ex_i.aluop)
            AND:     logic_res = op1 & op2;
            OR:      logic_res = op1 | op2;
            XOR:     logic_res = op1 ^ op2;
            NOR:     logic_res = ~(op1 | op2);
            LUI:     logic_res = {op2[15:0], 16'h0};
            default: logic_res = '0;
        endcase
    end

    always_comb begin
        case (id_ex_i.aluop)
            SLL:     shift_res = op1 << shamt;
            SRL:     shift_res = op1 >> shamt;
            SRA:     shift_res = reg_t'($signed(op1) >>> shamt);   // sign fill
            default: shift_res = '0;
        endcase
    end

    // group select
    always_comb begin
        case (id_ex_i.alusel)
            LOGIC:   result = logic_res;
            SHIFT:   result = shift_res;
            default: result = '0;
        endcase
    end

    assign wb_o.we    = id_ex_i.we;
    assign wb_o.waddr = id_ex_i.waddr;
    assign wb_o.wdata = result;

endmodule

// ==== regfile.sv ====
// reads are combinational with EX, MEM, WB forwarding; the WB write lands at the end of its cycle
module regfile import mips_pkg::*; (
    input  logic   clk,
    input  logic   rst_n_i,
    input  wb_t    ex_fwd_i,
    input  wb_t    mem_fwd_i,
    input  wb_t    wb_i,
    input  logic   re1_i,
    input  raddr_t raddr1_i,
    input  logic   re2_i,
    input  raddr_t raddr2_i,
    output reg_t   rdata1_o,
    output reg_t   rdata2_o
);

    reg_t regs [NUM_REGS];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.we && wb_i.waddr != '0) begin
            regs[wb_i.waddr] <= wb_i.wdata;
        end
    end

    // newest producer wins
    function automatic reg_t fwd_read(
        input logic   re,
        input raddr_t ra,
        input wb_t    ex_r,
        input wb_t    mem_r,
        input wb_t    wb_r,
        input reg_t   stored
    );
        reg_t val;
        if (!re || ra == '0) begin
            val = '0;
        end else if (ex_r.we && ex_r.waddr == ra) begin
            val = ex_r.wdata;
        end else if (mem_r.we && mem_r.waddr == ra) begin
            val = mem_r.wdata;
        end else if (wb_r.we && wb_r.waddr == ra) begin
            val = wb_r.wdata;     // not yet written this cycle
        end else begin
            val = stored;
        end
        return val;
    endfunction

    assign rdata1_o = fwd_read(re1_i, raddr1_i, ex_fwd_i, mem_fwd_i, wb_i, regs[raddr1_i]);
    assign rdata2_o = fwd_read(re2_i, raddr2_i, ex_fwd_i, mem_fwd_i, wb_i, regs[raddr2_i]);

    a_r0_zero: assert property (@(posedge clk) disable iff (!rst_n_i) regs[0] == '0)
        else $error("regfile: r0 holds a nonzero value");

endmodule

// ==== id.sv ====
// reserved R-type fields (rs of shifts, sa of logic ops) are not checked; r0 destinations drop we
module id import mips_pkg::*; (
    input  if_id_t if_id_i,
    input  reg_t   rdata1_i,
    input  reg_t   rdata2_i,
    output logic   re1_o,
    output raddr_t raddr1_o,
    output logic   re2_o,
    output raddr_t raddr2_o,
    output id_ex_t id_ex_o
);

    logic [5:0] opcode;
    logic [5:0] funct;
    raddr_t     rs;
    raddr_t     rt;
    raddr_t     rd;
    reg_t       imm_zext;
    reg_t       sa_zext;

    assign opcode   = if_id_i.inst[31:26];
    assign rs       = if_id_i.inst[25:21];
    assign rt       = if_id_i.inst[20:16];
    assign rd       = if_id_i.inst[15:11];
    assign funct    = if_id_i.inst[5:0];
    assign imm_zext = {16'h0, if_id_i.inst[15:0]};
    assign sa_zext  = {27'h0, if_id_i.inst[10:6]};

    always_comb begin
        alusel_e alusel;
        aluop_e  aluop;
        raddr_t  dest;
        logic    valid;
        reg_t    op2;

        alusel   = NOP;
        aluop    = AND;
        dest     = rd;
        valid    = 1'b1;
        op2      = rdata2_i;
        re1_o    = 1'b0;
        raddr1_o = rs;
        re2_o    = 1'b0;
        raddr2_o = rt;

        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FN_AND, FN_OR, FN_XOR, FN_NOR: begin
                        alusel = LOGIC;
                        re1_o  = 1'b1;
                        re2_o  = 1'b1;
                        unique case (funct)
                            FN_AND:  aluop = AND;
                            FN_OR:   aluop = OR;
                            FN_XOR:  aluop = XOR;
                            default: aluop = NOR;
                        endcase
                    end
                    FN_SLL, FN_SRL, FN_SRA: begin
                        alusel   = SHIFT;
                        re1_o    = 1'b1;
                        raddr1_o = rt;        // shifted value comes in on port 1
                        op2      = sa_zext;
                        unique case (funct)
                            FN_SLL:  aluop = SLL;
                            FN_SRL:  aluop = SRL;
                            default: aluop = SRA;
                        endcase
                    end
                    default: valid = 1'b0;
                endcase
            end
            OP_ANDI, OP_ORI, OP_XORI: begin
                alusel = LOGIC;
                re1_o  = 1'b1;
                dest   = rt;
                op2    = imm_zext;
                unique case (opcode)
                    OP_ANDI: aluop = AND;
                    OP_ORI:  aluop = OR;
                    default: aluop = XOR;
                endcase
            end
            OP_LUI: begin
                alusel = LOGIC;
                aluop  = LUI;
                dest   = rt;
                op2    = imm_zext;        // ex moves it to the upper half
            end
            default: valid = 1'b0;
        endcase

        if (!valid) begin
            re1_o   = 1'b0;
            re2_o   = 1'b0;
            id_ex_o = '0;                 // unknown word becomes a bubble
        end else begin
            id_ex_o.alusel = alusel;
            id_ex_o.aluop  = aluop;
            id_ex_o.op1    = rdata1_i;    // 0 when port 1 is not enabled
            id_ex_o.op2    = op2;
            id_ex_o.waddr  = dest;
            id_ex_o.we     = (dest != '0);
        end
    end

    // a live write must carry a real result group
    always_comb begin
        if (id_ex_o.we) begin
            assert (id_ex_o.alusel != NOP)
                else $error("id: write enabled with alusel NOP");
        end
    end

endmodule

// ==== pipe_reg.sv ====
// payload T must be a packed type whose all-zero value is a valid bubble
module pipe_reg #(
    parameter type T = logic [31:0]
) (
    input  logic clk,
    input  logic rst_n_i,
    input  T     d_i,
    output T     q_o
);

    // one stage boundary, no stall and no flush
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            q_o <= '0;    // bubble
        end else begin
            q_o <= d_i;
        end
    end

endmodule

// ==== pc_reg.sv ====
// pc reads 0 during reset and RESET_PC on the first fetch cycle; RESET_PC must be word aligned
module pc_reg import mips_pkg::*; #(
    parameter addr_t RESET_PC = '0
) (
    input  logic  clk,
    input  logic  rst_n_i,
    output addr_t pc_o,
    output logic  ce_o
);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ce_o <= 1'b0;
            pc_o <= '0;
        end else begin
            ce_o <= 1'b1;           // fetch runs from the first edge on
            if (!ce_o) begin
                pc_o <= RESET_PC;
            end else begin
                pc_o <= pc_o + addr_t'(4);
            end
        end
    end

    // no branches, so fetch is strictly sequential
    a_pc_step: assert property (@(posedge clk) disable iff (!rst_n_i)
        $past(ce_o) && ce_o |-> pc_o == $past(pc_o) + addr_t'(4))
        else $error("pc_reg: pc did not advance by 4");

endmodule

// ==== mips_pkg.sv ====
// all-zero stage records are bubbles, so alusel value 0 must remain NOP and we must stay low
package mips_pkg;

    localparam int INST_W   = 32;
    localparam int ADDR_W   = 32;
    localparam int REG_W    = 32;
    localparam int RADDR_W  = 5;
    localparam int NUM_REGS = 32;

    typedef logic [INST_W-1:0]  inst_t;
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [REG_W-1:0]   reg_t;
    typedef logic [RADDR_W-1:0] raddr_t;

    // result group picked in ex
    typedef enum logic [1:0] {
        NOP   = 2'd0,
        LOGIC = 2'd1,
        SHIFT = 2'd2
    } alusel_e;

    typedef enum logic [2:0] {
        AND = 3'd0,
        OR  = 3'd1,
        XOR = 3'd2,
        NOR = 3'd3,
        LUI = 3'd4,
        SLL = 3'd5,    // shifts take the amount from op2[4:0]
        SRL = 3'd6,
        SRA = 3'd7
    } aluop_e;

    // primary opcodes, inst[31:26]
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;

    // SPECIAL function field, inst[5:0]
    localparam logic [5:0] FN_SLL = 6'b000000;
    localparam logic [5:0] FN_SRL = 6'b000010;
    localparam logic [5:0] FN_SRA = 6'b000011;
    localparam logic [5:0] FN_AND = 6'b100100;
    localparam logic [5:0] FN_OR  = 6'b100101;
    localparam logic [5:0] FN_XOR = 6'b100110;
    localparam logic [5:0] FN_NOR = 6'b100111;

    // fetched word and its address
    typedef struct packed {
        addr_t pc;
        inst_t inst;
    } if_id_t;

    // decoded operation, operands already forwarded
    typedef struct packed {
        alusel_e alusel;
        aluop_e  aluop;
        reg_t    op1;
        reg_t    op2;
        raddr_t  waddr;
        logic    we;
    } id_ex_t;

    // register write record, also the forwarding source
    typedef struct packed {
        logic   we;
        raddr_t waddr;
        reg_t   wdata;
    } wb_t;

endpackage
